/* src/core_pkg.sv */
// Instruction set definitions for the three-stage integer core
// Opcodes, instruction field positions and register file size
package core_pkg;

  // Datapath and instruction word
  localparam int WORD_WIDTH = 32;

  // Register file
  localparam int REGISTER_INDEX_WIDTH = 3;
  localparam int REGISTER_COUNT = 8;

  // Field positions inside an instruction word
  localparam int OPCODE_WIDTH = 4;
  localparam int OPCODE_LSB = 28;
  localparam int RD_LSB = 25;
  localparam int RS1_LSB = 22;
  localparam int RS2_LSB = 19;

  // Immediate sits in the low bits, sign bit at IMM_WIDTH-1
  localparam int IMM_WIDTH = 16;

  // Eight instructions, no branches
  typedef enum logic [OPCODE_WIDTH-1:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_ADDI = 4'd4,
    OP_LW   = 4'd5,
    OP_SW   = 4'd6,
    OP_HALT = 4'd7
  } opcode_e;

endpackage

/* src/mem_pkg.sv */
// Memory system definitions
// Unified word memory geometry and arbiter ownership codes
package mem_pkg;

  // Word addressed, low address bits of a computed value
  localparam int ADDR_WIDTH = 8;
  localparam int DATA_WIDTH = 32;
  localparam int MEM_DEPTH = 256;

  // Who got the memory on the previous cycle
  typedef enum logic [1:0] {
    OWN_NONE  = 2'd0,
    OWN_LOAD  = 2'd1,
    OWN_DATA  = 2'd2,
    OWN_FETCH = 2'd3
  } owner_e;

endpackage

/* src/mem_port_if.sv */
// One requester's port onto the shared memory arbiter
// Level request, pulsed grant, read data one cycle after grant
interface mem_port_if import mem_pkg::*; ();

  // Requester side
  logic                  req;
  logic                  we;
  logic [ADDR_WIDTH-1:0] addr;
  logic [DATA_WIDTH-1:0] wdata;

  // Arbiter side
  logic                  gnt;
  logic                  rvalid;
  logic [DATA_WIDTH-1:0] rdata;

  modport requester (
    output req, we, addr, wdata,
    input  gnt, rvalid, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output gnt, rvalid, rdata
  );

endinterface

/* src/fetch_unit.sv */
// Instruction fetch stage
// Reads one word per request at the PC, holds it while execute stalls
module fetch_unit import core_pkg::*; import mem_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  run,
  input  logic                  stall,
  mem_port_if.requester         mem,
  output logic                  instr_valid,
  output logic [WORD_WIDTH-1:0] instr
);

  logic [ADDR_WIDTH-1:0] pc;
  logic                  hold_valid;
  logic [WORD_WIDTH-1:0] hold_instr;
  logic                  halt_seen;
  logic                  fetched_halt;

  // HALT word arriving from memory this cycle
  assign fetched_halt = mem.rvalid &&
    (opcode_e'(mem.rdata[OPCODE_LSB +: OPCODE_WIDTH]) == OP_HALT);

  // Read only; one access in flight and no new one while an instruction waits
  assign mem.req   = run && !halt_seen && !mem.rvalid && !hold_valid;
  assign mem.we    = 1'b0;
  assign mem.addr  = pc;
  assign mem.wdata = '0;

  // Fresh data goes straight through, held copy takes over on a stall
  assign instr_valid = hold_valid || mem.rvalid;
  assign instr       = hold_valid ? hold_instr : mem.rdata;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pc         <= '0;
      hold_valid <= 1'b0;
      halt_seen  <= 1'b0;
    end
    else
    begin
      // Advance once the access is granted
      if (mem.gnt)
        pc <= pc + 1'b1;
      // Keep the word until execute accepts it
      if (mem.rvalid && stall)
        hold_valid <= 1'b1;
      else if (!stall)
        hold_valid <= 1'b0;
      if (fetched_halt)
        halt_seen <= 1'b1;
    end
  end

  // Payload capture
  always_ff @(posedge clk)
  begin
    if (mem.rvalid)
      hold_instr <= mem.rdata;
  end

endmodule

/* src/execute_unit.sv */
// Execute stage
// Decode, register file with forwarding from writeback, hazard stall and ALU
module execute_unit import core_pkg::*; (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            instr_valid,
  input  logic [WORD_WIDTH-1:0]           instr,
  output logic                            stall,
  input  logic                            mem_busy,
  input  logic                            wb_valid,
  input  logic [REGISTER_INDEX_WIDTH-1:0] wb_reg,
  input  logic [WORD_WIDTH-1:0]           wb_data,
  output logic                            ex_valid,
  output logic [WORD_WIDTH-1:0]           instruction_out,
  output logic [WORD_WIDTH-1:0]           extended_immediate_out,
  output logic [WORD_WIDTH-1:0]           alu_result_out,
  output logic [WORD_WIDTH-1:0]           store_data_out,
  output logic                            mem_to_reg_out,
  output logic                            reg_write_out,
  output logic [REGISTER_INDEX_WIDTH-1:0] destination_register_out
);

  opcode_e                         op;
  logic [REGISTER_INDEX_WIDTH-1:0] rd;
  logic [REGISTER_INDEX_WIDTH-1:0] rs1;
  logic [REGISTER_INDEX_WIDTH-1:0] rs2;
  logic [WORD_WIDTH-1:0]           imm_ext;
  logic                            uses_rs1;
  logic                            uses_rs2;
  logic                            writes_rd;
  logic [WORD_WIDTH-1:0]           regs [REGISTER_COUNT];
  logic [WORD_WIDTH-1:0]           src1;
  logic [WORD_WIDTH-1:0]           src2;
  logic [WORD_WIDTH-1:0]           alu_result;
  logic                            ex_writes;
  logic                            pend_q;
  logic [REGISTER_INDEX_WIDTH-1:0] pend_reg_q;
  logic                            hit1;
  logic                            hit2;

  // Field split
  assign op  = opcode_e'(instr[OPCODE_LSB +: OPCODE_WIDTH]);
  assign rd  = instr[RD_LSB +: REGISTER_INDEX_WIDTH];
  assign rs1 = instr[RS1_LSB +: REGISTER_INDEX_WIDTH];
  assign rs2 = instr[RS2_LSB +: REGISTER_INDEX_WIDTH];
  assign imm_ext = {{(WORD_WIDTH-IMM_WIDTH){instr[IMM_WIDTH-1]}}, instr[IMM_WIDTH-1:0]};

  // Operand usage and register write per opcode
  assign uses_rs1  = op inside {OP_ADD, OP_SUB, OP_AND, OP_ADDI, OP_LW, OP_SW};
  assign uses_rs2  = op inside {OP_ADD, OP_SUB, OP_AND, OP_SW};
  assign writes_rd = op inside {OP_ADD, OP_SUB, OP_AND, OP_ADDI, OP_LW};

  // r0 reads as zero, writeback value bypasses the file in its own cycle
  assign src1 = (rs1 == '0) ? '0 :
                (wb_valid && wb_reg == rs1) ? wb_data : regs[rs1];
  assign src2 = (rs2 == '0) ? '0 :
                (wb_valid && wb_reg == rs2) ? wb_data : regs[rs2];

  always_comb
  begin
    case (op)
      OP_ADD:                 alu_result = src1 + src2;
      OP_SUB:                 alu_result = src1 - src2;
      OP_AND:                 alu_result = src1 & src2;
      // Effective address for memory ops
      OP_ADDI, OP_LW, OP_SW:  alu_result = src1 + imm_ext;
      default:                alu_result = '0;
    endcase
  end

  // Producer still sitting in the output register
  assign ex_writes = ex_valid && reg_write_out && (destination_register_out != '0);

  // Producer in the memory stage, cleared by its writeback pulse
  assign hit1 = uses_rs1 && rs1 != '0 &&
                ((ex_writes && destination_register_out == rs1) ||
                 (pend_q && pend_reg_q == rs1 && !(wb_valid && wb_reg == rs1)));
  assign hit2 = uses_rs2 && rs2 != '0 &&
                ((ex_writes && destination_register_out == rs2) ||
                 (pend_q && pend_reg_q == rs2 && !(wb_valid && wb_reg == rs2)));

  assign stall = mem_busy || (instr_valid && (hit1 || hit2));

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < REGISTER_COUNT; i++)
        regs[i] <= '0;
      ex_valid       <= 1'b0;
      mem_to_reg_out <= 1'b0;
      reg_write_out  <= 1'b0;
      pend_q         <= 1'b0;
      pend_reg_q     <= '0;
    end
    else
    begin
      if (wb_valid && wb_reg != '0)
        regs[wb_reg] <= wb_data;
      // Memory stage takes the output register whenever it is free
      if (!mem_busy)
        ex_valid <= instr_valid && !stall;
      if (!stall)
      begin
        mem_to_reg_out <= (op == OP_LW);
        reg_write_out  <= writes_rd;
      end
      // Track the destination handed over to the memory stage
      if (ex_valid && !mem_busy)
      begin
        pend_q     <= ex_writes;
        pend_reg_q <= destination_register_out;
      end
      else if (wb_valid)
        pend_q <= 1'b0;
    end
  end

  // Payload to the memory stage
  always_ff @(posedge clk)
  begin
    if (!stall)
    begin
      instruction_out          <= instr;
      extended_immediate_out   <= imm_ext;
      alu_result_out           <= alu_result;
      store_data_out           <= src2;
      destination_register_out <= rd;
    end
  end

endmodule

/* src/memory_registers.sv */
// Memory stage register bank
// Holds one instruction from execute, runs its load or store, drives writeback
module memory_registers import core_pkg::*; import mem_pkg::*; (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            ex_valid,
  input  logic [WORD_WIDTH-1:0]           instruction_in,
  input  logic [WORD_WIDTH-1:0]           extended_immediate_in,
  input  logic [WORD_WIDTH-1:0]           alu_result_in,
  input  logic [WORD_WIDTH-1:0]           store_data_in,
  input  logic                            mem_to_reg_in,
  input  logic                            reg_write_in,
  input  logic [REGISTER_INDEX_WIDTH-1:0] destination_register_in,
  mem_port_if.requester                   mem,
  output logic                            mem_busy,
  output logic                            wb_valid,
  output logic [REGISTER_INDEX_WIDTH-1:0] wb_reg,
  output logic [WORD_WIDTH-1:0]           wb_data,
  output logic                            halted
);

  logic                            valid_q;
  logic                            mem_to_reg_q;
  logic                            reg_write_q;
  logic                            wait_q;
  logic [WORD_WIDTH-1:0]           instruction_q;
  logic [WORD_WIDTH-1:0]           alu_result_q;
  logic [WORD_WIDTH-1:0]           store_data_q;
  logic [REGISTER_INDEX_WIDTH-1:0] dest_q;
  opcode_e                         op_q;
  logic                            is_store;
  logic                            done;

  assign op_q     = opcode_e'(instruction_q[OPCODE_LSB +: OPCODE_WIDTH]);
  assign is_store = (op_q == OP_SW);

  // Data port request at the ALU result address until granted
  assign mem.req   = valid_q && (mem_to_reg_q || is_store) && !wait_q;
  assign mem.we    = is_store;
  assign mem.addr  = alu_result_q[ADDR_WIDTH-1:0];
  assign mem.wdata = store_data_q;

  // Loads end on read data, stores at grant, the rest right away
  assign done = valid_q && (mem_to_reg_q ? mem.rvalid :
                           is_store     ? mem.gnt    : 1'b1);

  assign mem_busy = valid_q;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      valid_q      <= 1'b0;
      mem_to_reg_q <= 1'b0;
      reg_write_q  <= 1'b0;
      wait_q       <= 1'b0;
      wb_valid     <= 1'b0;
      halted       <= 1'b0;
    end
    else
    begin
      if (!valid_q)
      begin
        valid_q      <= ex_valid;
        mem_to_reg_q <= mem_to_reg_in;
        reg_write_q  <= reg_write_in;
      end
      else if (done)
        valid_q <= 1'b0;
      // Read granted so data is due next cycle
      if (mem.gnt && mem_to_reg_q)
        wait_q <= 1'b1;
      else if (mem.rvalid)
        wait_q <= 1'b0;
      // r0 writes are dropped here
      wb_valid <= done && reg_write_q && (dest_q != '0);
      if (valid_q && op_q == OP_HALT)
        halted <= 1'b1;
    end
  end

  // Bank payload and writeback data
  always_ff @(posedge clk)
  begin
    if (!valid_q)
    begin
      instruction_q <= instruction_in;
      alu_result_q  <= alu_result_in;
      store_data_q  <= store_data_in;
      dest_q        <= destination_register_in;
    end
    if (done)
    begin
      wb_reg  <= dest_q;
      // Loaded word, else ALU result
      wb_data <= mem_to_reg_q ? mem.rdata : alu_result_q;
    end
  end

endmodule

/* src/mem_arbiter.sv */
// Fixed-priority arbiter and unified synchronous word memory
// Program load first, then the data port, then fetch; one access per cycle
module mem_arbiter import mem_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  mem_port_if.arbiter           fetch,
  mem_port_if.arbiter           data,
  input  logic                  load_en,
  input  logic [ADDR_WIDTH-1:0] load_addr,
  input  logic [DATA_WIDTH-1:0] load_data
);

  logic [DATA_WIDTH-1:0] mem_array [MEM_DEPTH];
  owner_e                grant_now;
  owner_e                owner_q;
  logic [ADDR_WIDTH-1:0] sel_addr;
  logic                  sel_we;
  logic [DATA_WIDTH-1:0] sel_wdata;
  logic [DATA_WIDTH-1:0] read_q;

  // Pick the winner and its access
  always_comb
  begin
    grant_now = OWN_NONE;
    sel_addr  = fetch.addr;
    sel_we    = 1'b0;
    sel_wdata = data.wdata;
    if (load_en)
    begin
      grant_now = OWN_LOAD;
      sel_addr  = load_addr;
      sel_we    = 1'b1;
      sel_wdata = load_data;
    end
    else if (data.req)
    begin
      grant_now = OWN_DATA;
      sel_addr  = data.addr;
      sel_we    = data.we;
    end
    else if (fetch.req)
    begin
      grant_now = OWN_FETCH;
      sel_we    = fetch.we;
      sel_wdata = fetch.wdata;
    end
  end

  // Grant pulses, the requester drops req after it
  assign data.gnt  = (grant_now == OWN_DATA);
  assign fetch.gnt = (grant_now == OWN_FETCH);

  // Single-port memory with registered read
  always_ff @(posedge clk)
  begin
    if (grant_now != OWN_NONE && sel_we)
      mem_array[sel_addr] <= sel_wdata;
    read_q <= mem_array[sel_addr];
  end

  // Remember the reader so data returns to it
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      owner_q <= OWN_NONE;
    else
      owner_q <= sel_we ? OWN_NONE : grant_now;
  end

  assign data.rvalid  = (owner_q == OWN_DATA);
  assign fetch.rvalid = (owner_q == OWN_FETCH);
  assign data.rdata   = read_q;
  assign fetch.rdata  = read_q;

endmodule

/* src/pipeline_core.sv */
// Top of the three-stage integer core
// Fetch, execute and memory stages sharing one memory through the arbiter
module pipeline_core import core_pkg::*; import mem_pkg::*; (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            run,
  input  logic                            load_en,
  input  logic [ADDR_WIDTH-1:0]           load_addr,
  input  logic [DATA_WIDTH-1:0]           load_data,
  output logic                            wb_valid,
  output logic [REGISTER_INDEX_WIDTH-1:0] wb_reg,
  output logic [WORD_WIDTH-1:0]           wb_data,
  output logic                            halted
);

  logic                            instr_valid;
  logic [WORD_WIDTH-1:0]           instr;
  logic                            stall;
  logic                            mem_busy;
  logic                            ex_valid;
  logic [WORD_WIDTH-1:0]           instruction;
  logic [WORD_WIDTH-1:0]           extended_immediate;
  logic [WORD_WIDTH-1:0]           alu_result;
  logic [WORD_WIDTH-1:0]           store_data;
  logic                            mem_to_reg;
  logic                            reg_write;
  logic [REGISTER_INDEX_WIDTH-1:0] destination_register;

  // Fetch and data ports into the arbiter
  mem_port_if fetch_port ();
  mem_port_if data_port ();

  fetch_unit u_fetch (
    .clk         (clk),
    .arst_n      (arst_n),
    .run         (run),
    .stall       (stall),
    .mem         (fetch_port.requester),
    .instr_valid (instr_valid),
    .instr       (instr)
  );

  execute_unit u_execute (
    .clk                      (clk),
    .arst_n                   (arst_n),
    .instr_valid              (instr_valid),
    .instr                    (instr),
    .stall                    (stall),
    .mem_busy                 (mem_busy),
    .wb_valid                 (wb_valid),
    .wb_reg                   (wb_reg),
    .wb_data                  (wb_data),
    .ex_valid                 (ex_valid),
    .instruction_out          (instruction),
    .extended_immediate_out   (extended_immediate),
    .alu_result_out           (alu_result),
    .store_data_out           (store_data),
    .mem_to_reg_out           (mem_to_reg),
    .reg_write_out            (reg_write),
    .destination_register_out (destination_register)
  );

  memory_registers u_memory (
    .clk                     (clk),
    .arst_n                  (arst_n),
    .ex_valid                (ex_valid),
    .instruction_in          (instruction),
    .extended_immediate_in   (extended_immediate),
    .alu_result_in           (alu_result),
    .store_data_in           (store_data),
    .mem_to_reg_in           (mem_to_reg),
    .reg_write_in            (reg_write),
    .destination_register_in (destination_register),
    .mem                     (data_port.requester),
    .mem_busy                (mem_busy),
    .wb_valid                (wb_valid),
    .wb_reg                  (wb_reg),
    .wb_data                 (wb_data),
    .halted                  (halted)
  );

  mem_arbiter u_arbiter (
    .clk       (clk),
    .arst_n    (arst_n),
    .fetch     (fetch_port.arbiter),
    .data      (data_port.arbiter),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data)
  );

endmodule

/* verification/core_tb.sv */
// Testbench for the three-stage pipelined core
// Loads a short program, runs it and checks every writeback against an ISA model
module core_tb import core_pkg::*; import mem_pkg::*; ();

  localparam int PROG_LEN = 13;
  localparam int RESET_CYCLES = 5;
  localparam int LOAD_CYCLES = PROG_LEN + 6;
  // Generous budget per instruction covers stalls and arbitration
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + LOAD_CYCLES + 40 * PROG_LEN;
  localparam int HALT_HOLD = 20;
  localparam logic [ADDR_WIDTH-1:0] DATA_ADDR = 8'h80;
  localparam logic [ADDR_WIDTH-1:0] STORE_ADDR = 8'h90;
  localparam logic [DATA_WIDTH-1:0] DATA_WORD = 32'h5a3c_0f17;

  logic                            clk = 1'b0;
  logic                            arst_n;
  logic                            run;
  logic                            load_en;
  logic [ADDR_WIDTH-1:0]           load_addr;
  logic [DATA_WIDTH-1:0]           load_data;
  logic                            wb_valid;
  logic [REGISTER_INDEX_WIDTH-1:0] wb_reg;
  logic [WORD_WIDTH-1:0]           wb_data;
  logic                            halted;

  // Program image with the test each instruction belongs to
  logic [WORD_WIDTH-1:0]           prog [PROG_LEN];
  int                              prog_test [PROG_LEN];
  logic [WORD_WIDTH-1:0]           model_mem [MEM_DEPTH];
  // Expected writebacks in program order
  logic [REGISTER_INDEX_WIDTH-1:0] exp_reg [$];
  logic [WORD_WIDTH-1:0]           exp_val [$];
  int                              exp_test [$];
  int                              last_idx [7];
  int                              errors [7];
  int                              wb_count;
  int                              tests_passed;
  int                              tests_failed;
  integer                          seed = 11;

  pipeline_core uut (
    .clk       (clk),
    .arst_n    (arst_n),
    .run       (run),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .wb_valid  (wb_valid),
    .wb_reg    (wb_reg),
    .wb_data   (wb_data),
    .halted    (halted)
  );

  always #5 clk = ~clk;

  // opcode, rd, rs1, rs2, three spare bits, 16-bit immediate
  function automatic logic [WORD_WIDTH-1:0] encode(input opcode_e op, input logic [2:0] rd,
                                                   input logic [2:0] rs1, input logic [2:0] rs2,
                                                   input logic [15:0] imm);
    return {op, rd, rs1, rs2, 3'b000, imm};
  endfunction

  task automatic add_instr(input int idx, input logic [WORD_WIDTH-1:0] word, input int test);
    prog[idx] = word;
    prog_test[idx] = test;
  endtask

  task automatic build_program();
    logic [15:0] imm0;
    logic [15:0] imm1;
    logic [15:0] imm2;
    imm0 = 16'($random(seed));
    imm1 = 16'($random(seed));
    imm2 = 16'($random(seed));
    // Dependent ALU chain, each result feeds the next
    add_instr(0, encode(OP_ADDI, 3'd1, 3'd0, 3'd0, imm0), 2);
    add_instr(1, encode(OP_ADDI, 3'd2, 3'd1, 3'd0, imm1), 2);
    add_instr(2, encode(OP_ADD, 3'd3, 3'd1, 3'd2, 16'h0), 2);
    add_instr(3, encode(OP_SUB, 3'd4, 3'd3, 3'd1, 16'h0), 2);
    add_instr(4, encode(OP_AND, 3'd5, 3'd4, 3'd3, 16'h0), 2);
    // Preloaded data word
    add_instr(5, encode(OP_LW, 3'd6, 3'd0, 3'd0, 16'(DATA_ADDR)), 3);
    // Load-use, then store and reload of the sum
    add_instr(6, encode(OP_ADD, 3'd7, 3'd6, 3'd5, 16'h0), 4);
    add_instr(7, encode(OP_SW, 3'd0, 3'd0, 3'd7, 16'(STORE_ADDR)), 4);
    add_instr(8, encode(OP_LW, 3'd1, 3'd0, 3'd0, 16'(STORE_ADDR)), 4);
    add_instr(9, encode(OP_ADD, 3'd2, 3'd1, 3'd6, 16'h0), 4);
    // Write to r0 is dropped, r0 then reads as zero
    add_instr(10, encode(OP_ADDI, 3'd0, 3'd2, 3'd0, imm2), 5);
    add_instr(11, encode(OP_ADD, 3'd3, 3'd0, 3'd2, 16'h0), 5);
    add_instr(12, encode(OP_HALT, 3'd0, 3'd0, 3'd0, 16'h0), 6);
  endtask

  // Instruction-level model, one instruction at a time in program order
  task automatic run_model();
    logic [WORD_WIDTH-1:0] regs [REGISTER_COUNT];
    logic [WORD_WIDTH-1:0] w;
    logic [WORD_WIDTH-1:0] a;
    logic [WORD_WIDTH-1:0] b;
    logic [WORD_WIDTH-1:0] ea;
    logic [WORD_WIDTH-1:0] res;
    logic [2:0]            rd;
    opcode_e               op;
    logic                  wr;
    logic                  stop;
    int                    pc;
    for (int i = 0; i < REGISTER_COUNT; i++)
      regs[i] = '0;
    for (int i = 0; i < MEM_DEPTH; i++)
      model_mem[i] = '0;
    for (int i = 0; i < PROG_LEN; i++)
      model_mem[i] = prog[i];
    model_mem[DATA_ADDR] = DATA_WORD;
    pc = 0;
    stop = 1'b0;
    while (!stop && pc < PROG_LEN)
    begin
      w = model_mem[pc];
      op = opcode_e'(w[31:28]);
      rd = w[27:25];
      a = regs[w[24:22]];
      b = regs[w[21:19]];
      // Sign-extended immediate gives the address for loads and stores
      ea = a + {{16{w[15]}}, w[15:0]};
      res = '0;
      wr = 1'b1;
      case (op)
        OP_ADD:  res = a + b;
        OP_SUB:  res = a - b;
        OP_AND:  res = a & b;
        OP_ADDI: res = ea;
        OP_LW:   res = model_mem[ea[ADDR_WIDTH-1:0]];
        OP_SW:
        begin
          model_mem[ea[ADDR_WIDTH-1:0]] = b;
          wr = 1'b0;
        end
        OP_HALT:
        begin
          stop = 1'b1;
          wr = 1'b0;
        end
        default: wr = 1'b0;
      endcase
      if (wr && rd != 3'd0)
      begin
        regs[rd] = res;
        exp_reg.push_back(rd);
        exp_val.push_back(res);
        exp_test.push_back(prog_test[pc]);
      end
      pc++;
    end
  endtask

  task automatic report_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual, input int test);
    $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, expected, actual);
    errors[test]++;
  endtask

  task automatic report_test(input int test, input string name);
    if (errors[test] == 0)
    begin
      $display("Test %0d %s: ok", test, name);
      tests_passed++;
    end
    else
    begin
      $display("Test %0d %s: %0d errors", test, name, errors[test]);
      tests_failed++;
    end
  endtask

  // Outputs are sampled mid-cycle, away from the driving edge
  always @(negedge clk)
  begin
    if (arst_n && !run)
    begin
      assert (!wb_valid) else report_value("wb_valid", 32'd0, 32'(wb_valid), 1);
      assert (!halted) else report_value("halted", 32'd0, 32'(halted), 1);
    end
    if (arst_n && wb_valid)
    begin
      assert (wb_reg != '0)
      else
      begin
        $display("[FAIL] t=%0t a write to r0 reached writeback", $time);
        errors[5]++;
      end
      assert (wb_count < exp_reg.size())
      else
      begin
        $display("[FAIL] t=%0t writeback seen after all expected results", $time);
        errors[6]++;
      end
      if (wb_count < exp_reg.size())
      begin
        assert (wb_reg == exp_reg[wb_count])
          else report_value("wb_reg", 32'(exp_reg[wb_count]), 32'(wb_reg), exp_test[wb_count]);
        assert (wb_data == exp_val[wb_count])
          else report_value("wb_data", exp_val[wb_count], wb_data, exp_test[wb_count]);
      end
      wb_count++;
    end
  end

  initial
  begin
    #(WATCHDOG_CYCLES * 10);
    $display("Timeout after %0d cycles, the program did not complete", WATCHDOG_CYCLES);
    $display("Verification failed");
    $finish;
  end

  initial
  begin
    arst_n = 1'b0;
    run = 1'b0;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    build_program();
    run_model();
    // Index of the final writeback of each test
    for (int k = 0; k < exp_test.size(); k++)
      last_idx[exp_test[k]] = k;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    // Program load through the external port, core still idle
    for (int i = 0; i < PROG_LEN; i++)
    begin
      @(posedge clk);
      load_en <= 1'b1;
      load_addr <= 8'(i);
      load_data <= prog[i];
    end
    @(posedge clk);
    load_addr <= DATA_ADDR;
    load_data <= DATA_WORD;
    @(posedge clk);
    load_en <= 1'b0;
    repeat (3) @(posedge clk);
    report_test(1, "idle before run");
    run <= 1'b1;
    wait (wb_count > last_idx[2]);
    report_test(2, "dependent ALU chain");
    wait (wb_count > last_idx[3]);
    report_test(3, "load of preloaded word");
    wait (wb_count > last_idx[4]);
    report_test(4, "store then load-use");
    wait (wb_count > last_idx[5]);
    report_test(5, "r0 write dropped");
    wait (halted);
    // halted must hold and the pipeline must stay quiet
    repeat (HALT_HOLD)
    begin
      @(negedge clk);
      assert (halted) else report_value("halted", 32'd1, 32'(halted), 6);
      assert (!wb_valid) else report_value("wb_valid", 32'd0, 32'(wb_valid), 6);
    end
    assert (wb_count == exp_reg.size())
    else
    begin
      $display("[FAIL] t=%0t saw %0d writebacks but the model has %0d", $time, wb_count,
               exp_reg.size());
      errors[6]++;
    end
    report_test(6, "halt");
    $display("Tests ok: %0d, with errors: %0d", tests_passed, tests_failed);
    if (tests_failed == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

/* vlog.f */
src/core_pkg.sv
src/mem_pkg.sv
src/mem_port_if.sv
src/fetch_unit.sv
src/execute_unit.sv
src/memory_registers.sv
src/mem_arbiter.sv
src/pipeline_core.sv
verification/core_tb.sv

/* Makefile */
# Verilator build and run of the pipelined core testbench
TOP = core_tb

all: run

run:
	verilator --binary --assert -j 0 --top-module $(TOP) -f vlog.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -qx "Verification passed"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
